// File: snd_pkg.sv
// audio types shared by the voices and the mixer
package snd_pkg;

    // signed 16-bit audio sample, full scale both ways
    typedef logic signed [15:0] sample_t;

    // 4.4 fixed point gain, 8'h10 is unity
    typedef logic [7:0] gain_t;

    // width of the unsigned volume field in the tone voice
    typedef logic [7:0] volume_t;

    // unsigned pcm byte as stored in the sample ram
    typedef logic [7:0] pcm_byte_t;

    localparam gain_t TONE_GAIN_RST = 8'h10; // tone at unity
    localparam gain_t PCM_GAIN_RST  = 8'h08; // pcm at half

    // sample ram size in bytes
    localparam int PCM_RAM_SIZE = 1024;

    // left shifts that scale each voice up to 16 bits
    localparam int TONE_SHIFT = 7;
    localparam int PCM_SHIFT  = 8;

    // gain has 4 fractional bits
    localparam int GAIN_FRAC = 4;

endpackage

// File: cmd_pkg.sv
// command word layout and opcodes
package cmd_pkg;

    typedef logic [15:0] cmd_word_t; // op in 15:12, arg in 11:0
    typedef logic [3:0]  cmd_op_t;
    typedef logic [11:0] cmd_arg_t;
    typedef logic [9:0]  pcm_addr_t; // 1k sample ram

    localparam cmd_op_t OP_TONE_PERIOD = 4'h1; // half period in ticks, 0 mutes
    localparam cmd_op_t OP_TONE_VOL    = 4'h2; // arg 7:0
    localparam cmd_op_t OP_TONE_GAIN   = 4'h3; // arg 7:0, 4.4
    localparam cmd_op_t OP_PCM_START   = 4'h4; // arg 9:0
    localparam cmd_op_t OP_PCM_LEN     = 4'h5; // arg 9:0, also starts playback
    localparam cmd_op_t OP_PCM_GAIN    = 4'h6; // arg 7:0, 4.4

    function automatic cmd_op_t cmd_op(input cmd_word_t w);
        return w[15:12];
    endfunction

    function automatic cmd_arg_t cmd_arg(input cmd_word_t w);
        return w[11:0];
    endfunction

    // tone voice owns three opcodes
    function automatic logic is_tone_op(input cmd_op_t op);
        return op == OP_TONE_PERIOD || op == OP_TONE_VOL || op == OP_TONE_GAIN;
    endfunction

    function automatic logic is_pcm_op(input cmd_op_t op);
        return op == OP_PCM_START || op == OP_PCM_LEN || op == OP_PCM_GAIN;
    endfunction

endpackage

// File: voice_ctrl_if.sv
// decoded command writes to the voices
`timescale 1ns/1ps

interface voice_ctrl_if;

    logic               tone_wr; // one cycle strobe
    logic               pcm_wr;  // one cycle strobe
    cmd_pkg::cmd_op_t   op;
    cmd_pkg::cmd_arg_t  arg;

    // queue side drives everything
    modport queue (
        output tone_wr,
        output pcm_wr,
        output op,
        output arg
    );

    // voices only listen, no back-pressure
    modport voice (
        input  tone_wr,
        input  pcm_wr,
        input  op,
        input  arg
    );

endinterface

// File: snd_cmd_queue.sv
// command queue with credit return
`timescale 1ns/1ps

module snd_cmd_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  cmd_pkg::cmd_word_t  cmd_data,
    output logic                cmd_credit,
    voice_ctrl_if.queue         ctrl
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    cmd_pkg::cmd_word_t mem [QUEUE_DEPTH]; // payload only

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    cmd_pkg::cmd_word_t head;
    cmd_pkg::cmd_op_t   head_op;

    assign full  = count == CW'(QUEUE_DEPTH);
    assign empty = count == '0;

    // host spends credits, so full never sees cmd_valid
    assign push = cmd_valid && !full;
    assign pop  = !empty; // drain one per cycle

    assign head    = mem[rd_ptr];
    assign head_op = cmd_pkg::cmd_op(head);

    // dispatch straight from the head entry
    assign ctrl.op      = head_op;
    assign ctrl.arg     = cmd_pkg::cmd_arg(head);
    assign ctrl.tone_wr = pop && cmd_pkg::is_tone_op(head_op);
    assign ctrl.pcm_wr  = pop && cmd_pkg::is_pcm_op(head_op);

    // unknown ops pop too, so every pop frees a credit
    assign cmd_credit = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // explicit wrap, depth need not be a power of two
                wr_ptr <= (wr_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or none
            endcase
        end
    end

endmodule

// File: snd_tone.sv
// square wave tone voice
`timescale 1ns/1ps

module snd_tone (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_cen,
    voice_ctrl_if.voice         ctrl,
    output snd_pkg::sample_t    tone,
    output snd_pkg::gain_t      tone_gain
);

    cmd_pkg::cmd_arg_t  period;   // half period in ticks
    snd_pkg::volume_t   vol;
    cmd_pkg::cmd_arg_t  cnt;      // ticks into the half period
    cmd_pkg::cmd_arg_t  cnt_next;
    logic               pol_neg;  // 0 = positive half

    snd_pkg::sample_t   tone_mag;

    assign cnt_next = cnt + 1'b1;
    assign tone_mag = snd_pkg::sample_t'({1'b0, vol}) <<< snd_pkg::TONE_SHIFT;

    always_ff @(posedge clk) begin
        if (reset) begin
            period    <= '0;
            vol       <= '0;
            cnt       <= '0;
            pol_neg   <= 1'b0;
            tone      <= '0;
            tone_gain <= snd_pkg::TONE_GAIN_RST;
        end else begin
            if (sample_cen) begin
                if (period == '0) begin
                    tone <= '0; // muted
                end else begin
                    tone <= pol_neg ? -tone_mag : tone_mag; // current half
                    if (cnt_next == period) begin
                        cnt     <= '0;
                        pol_neg <= ~pol_neg;
                    end else begin
                        cnt <= cnt_next;
                    end
                end
            end
            // register writes win over the tick
            if (ctrl.tone_wr) begin
                case (ctrl.op)
                    cmd_pkg::OP_TONE_PERIOD: begin
                        period  <= ctrl.arg;
                        cnt     <= '0;
                        pol_neg <= 1'b0; // restart on positive half
                    end
                    cmd_pkg::OP_TONE_VOL:  vol       <= ctrl.arg[7:0];
                    cmd_pkg::OP_TONE_GAIN: tone_gain <= ctrl.arg[7:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: snd_pcm.sv
// pcm sample player
`timescale 1ns/1ps

module snd_pcm (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_cen,
    voice_ctrl_if.voice         ctrl,
    input  cmd_pkg::pcm_addr_t  prog_addr,
    input  logic                prog_we,
    input  snd_pkg::pcm_byte_t  prog_data,
    output snd_pkg::sample_t    pcm,
    output snd_pkg::gain_t      pcm_gain,
    output logic                busy
);

    typedef enum logic {
        pcm_idle,
        pcm_play
    } pcm_state_t;

    pcm_state_t state;

    // loaded by the host before playback, like a prom
    snd_pkg::pcm_byte_t ram [snd_pkg::PCM_RAM_SIZE];

    cmd_pkg::pcm_addr_t start_addr;
    cmd_pkg::pcm_addr_t addr;      // current read address
    cmd_pkg::pcm_addr_t remain;    // samples left to play
    snd_pkg::pcm_byte_t rd_byte;
    snd_pkg::sample_t   rd_sample;

    assign rd_byte = ram[addr];
    // unsigned to signed, msb flip is minus 128
    assign rd_sample = snd_pkg::sample_t'({~rd_byte[7], rd_byte[6:0]}) <<< snd_pkg::PCM_SHIFT;

    assign busy = state == pcm_play;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            ram[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= pcm_idle;
            start_addr <= '0;
            addr       <= '0;
            remain     <= '0;
            pcm        <= '0;
            pcm_gain   <= snd_pkg::PCM_GAIN_RST;
        end else begin
            if (sample_cen) begin
                if (state == pcm_play) begin
                    pcm    <= rd_sample;
                    addr   <= addr + 1'b1; // wraps at 1k
                    remain <= remain - 1'b1;
                    if (remain == cmd_pkg::pcm_addr_t'(1)) begin
                        state <= pcm_idle; // last sample out
                    end
                end else begin
                    pcm <= '0;
                end
            end
            if (ctrl.pcm_wr) begin
                case (ctrl.op)
                    cmd_pkg::OP_PCM_START: start_addr <= ctrl.arg[9:0];
                    cmd_pkg::OP_PCM_LEN: begin
                        addr   <= start_addr;
                        remain <= ctrl.arg[9:0];
                        // zero length just stops
                        state  <= (ctrl.arg[9:0] != '0) ? pcm_play : pcm_idle;
                    end
                    cmd_pkg::OP_PCM_GAIN:  pcm_gain <= ctrl.arg[7:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: snd_mixer.sv
// two channel mixer with saturation
`timescale 1ns/1ps

module snd_mixer (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_cen,
    input  snd_pkg::sample_t    tone,
    input  snd_pkg::gain_t      tone_gain,
    input  snd_pkg::sample_t    pcm,
    input  snd_pkg::gain_t      pcm_gain,
    output snd_pkg::sample_t    snd,
    output logic                sample,
    output logic                peak
);

    logic               cen_d;     // voices valid this cycle

    // 16 bit sample times 9 bit signed gain
    logic signed [24:0] tone_prod;
    logic signed [24:0] pcm_prod;
    logic signed [25:0] mix_sum;   // one bit of headroom for the add
    logic signed [25:0] mix_shr;   // back to integer scale
    logic               ovf;
    snd_pkg::sample_t   mix_sat;

    assign tone_prod = tone * $signed({1'b0, tone_gain});
    assign pcm_prod  = pcm * $signed({1'b0, pcm_gain});
    assign mix_sum   = tone_prod + pcm_prod;
    assign mix_shr   = mix_sum >>> snd_pkg::GAIN_FRAC;

    // fits in 16 bits only if bits 25:15 agree
    assign ovf = !((&mix_shr[25:15]) || (~|mix_shr[25:15]));

    always_comb begin
        if (!ovf) begin
            mix_sat = mix_shr[15:0];
        end else if (mix_shr[25]) begin
            mix_sat = 16'sh8000; // clamp low
        end else begin
            mix_sat = 16'sh7fff; // clamp high
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cen_d  <= 1'b0;
            snd    <= '0;
            sample <= 1'b0;
            peak   <= 1'b0;
        end else begin
            cen_d  <= sample_cen;
            sample <= cen_d; // two cycles after the tick
            if (cen_d) begin
                snd  <= mix_sat;
                peak <= ovf; // held until the next sample
            end
        end
    end

endmodule

// File: snd_top.sv
// sound board top level
`timescale 1ns/1ps

module snd_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset,
    // command input, credit flow control
    input  logic                cmd_valid,
    input  cmd_pkg::cmd_word_t  cmd_data,
    output logic                cmd_credit,
    input  logic                sample_cen,
    // sample ram load
    input  cmd_pkg::pcm_addr_t  prog_addr,
    input  logic                prog_we,
    input  snd_pkg::pcm_byte_t  prog_data,
    // audio out
    output snd_pkg::sample_t    snd,
    output logic                sample,
    output logic                peak,
    output logic                pcm_busy
);

    voice_ctrl_if ctrl ();

    snd_pkg::sample_t tone;
    snd_pkg::gain_t   tone_gain;
    snd_pkg::sample_t pcm;
    snd_pkg::gain_t   pcm_gain;

    snd_cmd_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) u_queue (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cmd_valid  ( cmd_valid  ),
        .cmd_data   ( cmd_data   ),
        .cmd_credit ( cmd_credit ),
        .ctrl       ( ctrl.queue )
    );

    snd_tone u_tone (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sample_cen ( sample_cen ),
        .ctrl       ( ctrl.voice ),
        .tone       ( tone       ),
        .tone_gain  ( tone_gain  )
    );

    snd_pcm u_pcm (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sample_cen ( sample_cen ),
        .ctrl       ( ctrl.voice ),
        .prog_addr  ( prog_addr  ),
        .prog_we    ( prog_we    ),
        .prog_data  ( prog_data  ),
        .pcm        ( pcm        ),
        .pcm_gain   ( pcm_gain   ),
        .busy       ( pcm_busy   )
    );

    snd_mixer u_mixer (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sample_cen ( sample_cen ),
        .tone       ( tone       ),
        .tone_gain  ( tone_gain  ),
        .pcm        ( pcm        ),
        .pcm_gain   ( pcm_gain   ),
        .snd        ( snd        ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

endmodule

// File: snd_sva.sv
// command queue assertions
`timescale 1ns/1ps

module snd_sva #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                               clk,
    input logic                               reset,
    input logic                               cmd_valid,
    input logic                               full,
    input logic [$clog2(QUEUE_DEPTH + 1)-1:0] count,
    input logic                               tone_wr,
    input logic                               pcm_wr
);

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    // host holds off when out of credits
    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(cmd_valid && full))
        else $error("command pushed into a full queue");

    count_in_range: assert property (@(posedge clk) disable iff (reset)
        count <= CW'(QUEUE_DEPTH))
        else $error("queue count above depth");

    // one opcode per pop, so one voice at most
    one_voice_write: assert property (@(posedge clk) disable iff (reset)
        !(tone_wr && pcm_wr))
        else $error("tone and pcm written in the same cycle");

endmodule

bind snd_cmd_queue snd_sva #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_snd_sva (
    .clk       ( clk          ),
    .reset     ( reset        ),
    .cmd_valid ( cmd_valid    ),
    .full      ( full         ),
    .count     ( count        ),
    .tone_wr   ( ctrl.tone_wr ),
    .pcm_wr    ( ctrl.pcm_wr  )
);

// File: tb_snd.sv
// sound board testbench
`timescale 1ns/1ps

module tb_snd;

    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_TICKS   = 160;
    localparam int TICK_CYCLES = 16;
    // reset, ram load, all ticks, then a margin
    localparam int TIMEOUT_NS  = (10 + 1024 + NUM_TICKS * TICK_CYCLES + 100) * 10;

    logic               clk = 1'b0;
    logic               reset = 1'b1;
    logic               cmd_valid = 1'b0;
    cmd_pkg::cmd_word_t cmd_data = '0;
    logic               sample_cen = 1'b0;
    cmd_pkg::pcm_addr_t prog_addr = '0;
    logic               prog_we = 1'b0;
    snd_pkg::pcm_byte_t prog_data = '0;
    logic               cmd_credit;
    snd_pkg::sample_t   snd;
    logic               sample;
    logic               peak;
    logic               pcm_busy;

    logic [31:0] rng = 32'd97;  // xorshift state
    int    issued = 0;          // host side credit bookkeeping
    int    returned = 0;
    int    ticks_sent = 0;
    int    samples_seen = 0;
    int    peaks = 0;
    int    burst_len = 0;
    string test_name = "reset";
    // reference model state
    int    ram_model [1024];
    int    t_period = 0;
    int    t_vol = 0;
    int    t_gain = 16;         // unity
    int    t_cnt = 0;
    logic  t_neg = 1'b0;
    int    p_start = 0;
    int    p_addr = 0;
    int    p_remain = 0;
    int    p_gain = 8;          // half
    logic  p_play = 1'b0;
    int    exp_snd = 0;
    logic  exp_peak = 1'b0;
    logic  exp_busy = 1'b0;

    snd_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_snd_top (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            abort_run($sformatf("mismatch %s %s expected %0d actual %0d",
                                test_name, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(xorshift32() % (hi - lo + 1));
    endfunction

    function automatic cmd_pkg::cmd_word_t make_cmd(input cmd_pkg::cmd_op_t op, input int arg);
        return {op, cmd_pkg::cmd_arg_t'(arg)};
    endfunction

    // model side of a command, unknown opcodes fall through
    task automatic apply_cmd(input cmd_pkg::cmd_word_t w);
        int arg;
        arg = int'(w[11:0]);
        case (w[15:12])
            cmd_pkg::OP_TONE_PERIOD: begin
                t_period = arg;
                t_cnt    = 0;
                t_neg    = 1'b0;
            end
            cmd_pkg::OP_TONE_VOL:  t_vol   = arg & 255;
            cmd_pkg::OP_TONE_GAIN: t_gain  = arg & 255;
            cmd_pkg::OP_PCM_START: p_start = arg & 1023;
            cmd_pkg::OP_PCM_LEN: begin
                p_addr   = p_start;
                p_remain = arg & 1023;
                p_play   = p_remain != 0;
            end
            cmd_pkg::OP_PCM_GAIN:  p_gain  = arg & 255;
            default: ;
        endcase
    endtask

    // one sample tick through tone, pcm and mixer
    task automatic model_tick();
        int tone_s;
        int pcm_s;
        int mix;
        tone_s = 0;
        pcm_s  = 0;
        if (t_period != 0) begin
            tone_s = t_neg ? -(t_vol * 128) : t_vol * 128;
            t_cnt  = t_cnt + 1;
            if (t_cnt == t_period) begin
                t_cnt = 0;
                t_neg = !t_neg;
            end
        end
        if (p_play) begin
            pcm_s    = (ram_model[p_addr] - 128) * 256;
            p_addr   = (p_addr + 1) % 1024;
            p_remain = p_remain - 1;
            p_play   = p_remain != 0;
        end
        mix      = (tone_s * t_gain + pcm_s * p_gain) >>> 4; // drop 4.4 fraction
        exp_peak = mix > 32767 || mix < -32768;
        exp_snd  = exp_peak ? (mix > 0 ? 32767 : -32768) : mix;
        exp_busy = p_play;
    endtask

    task automatic send_cmd(input cmd_pkg::cmd_word_t w);
        if (QUEUE_DEPTH - issued + returned == 0) begin
            abort_run("host tried to send a command with no credit left");
        end
        cmd_valid <= 1'b1;
        cmd_data  <= w;
        issued    = issued + 1;
        burst_len = burst_len + 1;
        apply_cmd(w);
        @(posedge clk);
    endtask

    task automatic issue_for_tick(input int i);
        if (i >= 4 && i < 40 && i % 8 == 4) begin
            send_cmd(make_cmd(cmd_pkg::OP_TONE_PERIOD, rand_range(1, 6)));
            send_cmd(make_cmd(cmd_pkg::OP_TONE_VOL, rand_range(0, 255)));
        end else if (i == 40 || i == 60) begin
            send_cmd(make_cmd(cmd_pkg::OP_TONE_PERIOD, 0)); // tone off
            send_cmd(make_cmd(cmd_pkg::OP_PCM_START, rand_range(0, 1023)));
            send_cmd(make_cmd(cmd_pkg::OP_PCM_LEN, rand_range(1, 16)));
        end else if (i >= 80 && i < 110 && i % 5 == 0) begin
            // loud voices, gains above unity
            send_cmd(make_cmd(cmd_pkg::OP_TONE_PERIOD, rand_range(1, 4)));
            send_cmd(make_cmd(cmd_pkg::OP_TONE_VOL, rand_range(200, 255)));
            send_cmd(make_cmd(cmd_pkg::OP_TONE_GAIN, rand_range(16, 255)));
            send_cmd(make_cmd(cmd_pkg::OP_PCM_GAIN, rand_range(16, 255)));
        end else if (i >= 80 && i < 110 && i % 5 == 1) begin
            send_cmd(make_cmd(cmd_pkg::OP_PCM_START, rand_range(0, 1023)));
            send_cmd(make_cmd(cmd_pkg::OP_PCM_LEN, rand_range(1, 8)));
        end else if (i >= 110) begin
            repeat (rand_range(0, QUEUE_DEPTH)) send_cmd(cmd_pkg::cmd_word_t'(xorshift32()));
        end
    endtask

    task automatic run_tick(input int i);
        test_name = i < 4 ? "quiet" : i < 40 ? "tone" : i < 80 ? "pcm" :
                    i < 110 ? "saturation" : "credits";
        if (samples_seen != ticks_sent) begin
            abort_run("no sample pulse within the tick period");
        end
        compare_value("credits before tick", QUEUE_DEPTH, QUEUE_DEPTH - issued + returned);
        sample_cen <= 1'b1;
        @(posedge clk);
        sample_cen <= 1'b0;
        model_tick();
        ticks_sent = ticks_sent + 1;
        burst_len  = 0;
        issue_for_tick(i);
        cmd_valid <= 1'b0;
        repeat (TICK_CYCLES - 1 - burst_len) @(posedge clk);
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && cmd_credit) returned = returned + 1;
        if (sample) begin
            if (samples_seen >= ticks_sent) abort_run("sample pulse with no tick before it");
            samples_seen = samples_seen + 1;
            compare_value("snd", exp_snd, int'(snd));
            compare_value("peak", int'(exp_peak), int'(peak));
            compare_value("pcm_busy", int'(exp_busy), int'(pcm_busy));
            if (peak) peaks = peaks + 1;
        end
    end

    initial begin
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_value("snd after reset", 0, int'(snd));
        compare_value("flags after reset", 0, int'({sample, peak, cmd_credit, pcm_busy}));
        @(posedge clk);
        // fill the sample ram, one byte per cycle
        for (int a = 0; a < 1024; a++) begin
            ram_model[a] = rand_range(0, 255);
            prog_we   <= 1'b1;
            prog_addr <= cmd_pkg::pcm_addr_t'(a);
            prog_data <= snd_pkg::pcm_byte_t'(ram_model[a]);
            @(posedge clk);
        end
        prog_we <= 1'b0;
        for (int i = 0; i < NUM_TICKS; i++) run_tick(i);
        test_name = "end";
        compare_value("credits returned", issued, returned);
        compare_value("sample pulses", ticks_sent, samples_seen);
        compare_value("saturated samples seen", 1, int'(peaks > 0));
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout, the run did not finish in time");
    end

endmodule

// File: flist.f
snd_pkg.sv
cmd_pkg.sv
voice_ctrl_if.sv
snd_cmd_queue.sv
snd_tone.sv
snd_pcm.sv
snd_mixer.sv
snd_top.sv
snd_sva.sv
tb_snd.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_snd
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
